// ==== acc_pkg.sv ====
package acc_pkg;

  localparam int DATA_BITS = 32;
  localparam int ADDR_BITS = 8;
  localparam int BUF_WORDS = 1 << ADDR_BITS; // 256 words of output buffer.

  // field positions inside a host command word.
  localparam int CMD_OP_MSB    = 31;
  localparam int CMD_OP_LSB    = 30;
  localparam int CMD_COUNT_MSB = 23;
  localparam int CMD_COUNT_LSB = 16;
  localparam int CMD_BASE_MSB  = 15;
  localparam int CMD_BASE_LSB  = 8;
  localparam int CMD_BIAS_MSB  = 7;
  localparam int CMD_BIAS_LSB  = 0;

  localparam int COUNT_BITS = CMD_COUNT_MSB - CMD_COUNT_LSB + 1;
  localparam int BIAS_BITS  = CMD_BIAS_MSB - CMD_BIAS_LSB + 1;

  typedef enum logic [1:0] {
    OP_PASS      = 2'd0,
    OP_BIAS_RELU = 2'd1,
    OP_ACC       = 2'd2,
    OP_NOP       = 2'd3
  } epu_op_t;

  typedef enum logic [1:0] {
    OWN_IDLE   = 2'd0,
    OWN_EPU    = 2'd1,
    OWN_HOST_R = 2'd2,
    OWN_HOST_W = 2'd3
  } buf_owner_t;

  typedef enum logic [1:0] {
    EX_IDLE   = 2'd0,
    EX_RUN    = 2'd1,
    EX_ACC_WR = 2'd2
  } exec_state_t;

endpackage

// ==== out_buf_sram.sv ====
`timescale 1ns/1ps

module out_buf_sram
  import acc_pkg::*;
(
  input  logic                 clk,
  input  logic                 cs_i,
  input  logic                 oe_i,
  input  logic                 we_i,
  input  logic [ADDR_BITS-1:0] addr_i,
  input  logic [DATA_BITS-1:0] wdata_i,
  output logic [DATA_BITS-1:0] rdata_o
);

  logic [DATA_BITS-1:0] mem [BUF_WORDS];

  always_ff @(posedge clk) begin
    if (cs_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
    // read port is registered, so data shows one cycle after the request.
    if (cs_i && oe_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// ==== out_buf_wrapper.sv ====
`timescale 1ns/1ps

module out_buf_wrapper
  import acc_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enb_i,
  input  logic                 host_ar_hs_i,
  input  logic                 host_aw_hs_i,
  input  logic                 host_rd_fin_i,
  input  logic                 host_cs_i,
  input  logic                 host_oe_i,
  input  logic [ADDR_BITS-1:0] host_addr_i,
  input  logic [DATA_BITS-1:0] host_wdata_i,
  input  logic                 epu_cs_i,
  input  logic                 epu_oe_i,
  input  logic                 epu_we_i,
  input  logic [ADDR_BITS-1:0] epu_addr_i,
  input  logic [DATA_BITS-1:0] epu_wdata_i,
  output logic                 host_rvalid_o,
  output logic [DATA_BITS-1:0] host_rdata_o,
  output logic [DATA_BITS-1:0] epu_rdata_o
);

  buf_owner_t owner_q, owner_d;

  logic                 sram_cs;
  logic                 sram_oe;
  logic                 sram_we;
  logic [ADDR_BITS-1:0] sram_addr;
  logic [DATA_BITS-1:0] sram_wdata;
  logic [DATA_BITS-1:0] sram_rdata;

  out_buf_sram i_sram (
    .clk     (clk),
    .cs_i    (sram_cs),
    .oe_i    (sram_oe),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      owner_q       <= OWN_IDLE;
      host_rvalid_o <= 1'b0;
    end else begin
      owner_q       <= owner_d;
      host_rvalid_o <= (owner_q == OWN_HOST_R) && host_cs_i && host_oe_i;
    end
  end

  always_comb begin
    owner_d = owner_q;
    case (owner_q)
      OWN_IDLE, OWN_EPU: begin
        if (host_ar_hs_i && enb_i) owner_d = OWN_HOST_R; // reads win over writes.
        else if (host_aw_hs_i && enb_i) owner_d = OWN_HOST_W;
      end
      OWN_HOST_R, OWN_HOST_W: begin
        if (host_rd_fin_i && enb_i) owner_d = OWN_EPU;
      end
      default: owner_d = OWN_IDLE;
    endcase
  end

  always_comb begin
    sram_cs      = 1'b0;
    sram_oe      = 1'b0;
    sram_we      = 1'b0;
    sram_addr    = '0;
    sram_wdata   = '0;
    host_rdata_o = '0;
    epu_rdata_o  = '0;
    case (owner_q)
      OWN_EPU: begin
        sram_cs     = epu_cs_i;
        sram_oe     = epu_oe_i;
        sram_we     = epu_we_i;
        sram_addr   = epu_addr_i;
        sram_wdata  = epu_wdata_i;
        epu_rdata_o = sram_rdata;
      end
      OWN_HOST_R: begin
        sram_cs      = host_cs_i;
        sram_oe      = host_oe_i;
        sram_addr    = host_addr_i;
        host_rdata_o = sram_rdata;
      end
      OWN_HOST_W: begin
        sram_cs    = host_cs_i;
        sram_oe    = host_oe_i;
        sram_we    = 1'b1; // a write access always writes while selected.
        sram_addr  = host_addr_i;
        sram_wdata = host_wdata_i;
      end
      default: ;
    endcase
  end

endmodule

// ==== epu_cmd_decode.sv ====
`timescale 1ns/1ps

module epu_cmd_decode
  import acc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enb_i,
  input  logic                  cmd_valid_i,
  input  logic [DATA_BITS-1:0]  cmd_i,
  input  logic                  busy_i,
  output logic                  start_o,
  output epu_op_t               op_o,
  output logic [ADDR_BITS-1:0]  base_o,
  output logic [COUNT_BITS-1:0] count_o,
  output logic [BIAS_BITS-1:0]  bias_o,
  output logic                  cmd_err_o
);

  logic engaged;
  logic accept;

  // busy only rises the cycle after start, so a pending start also counts as engaged.
  assign engaged = busy_i || start_o;
  assign accept  = cmd_valid_i && enb_i && !engaged;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      start_o   <= 1'b0;
      cmd_err_o <= 1'b0;
    end else begin
      start_o   <= accept;
      cmd_err_o <= cmd_valid_i && engaged; // the command is dropped.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_o    <= epu_op_t'(cmd_i[CMD_OP_MSB:CMD_OP_LSB]);
      base_o  <= cmd_i[CMD_BASE_MSB:CMD_BASE_LSB];
      count_o <= cmd_i[CMD_COUNT_MSB:CMD_COUNT_LSB];
      bias_o  <= cmd_i[CMD_BIAS_MSB:CMD_BIAS_LSB];
    end
  end

endmodule

// ==== epu_post_exec.sv ====
`timescale 1ns/1ps

module epu_post_exec
  import acc_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start_i,
  input  epu_op_t                      op_i,
  input  logic        [ADDR_BITS-1:0]  base_i,
  input  logic        [COUNT_BITS-1:0] count_i,
  input  logic        [BIAS_BITS-1:0]  bias_i,
  input  logic                         psum_valid_i,
  input  logic signed [DATA_BITS-1:0]  psum_i,
  input  logic        [DATA_BITS-1:0]  rdata_i,
  output logic                         cs_o,
  output logic                         oe_o,
  output logic                         we_o,
  output logic        [ADDR_BITS-1:0]  addr_o,
  output logic        [DATA_BITS-1:0]  wdata_o,
  output logic                         busy_o,
  output logic                         done_o
);

  exec_state_t state_q;

  logic        [ADDR_BITS-1:0]  addr_q;
  logic        [COUNT_BITS-1:0] remain_q;
  epu_op_t                      op_q;
  logic        [BIAS_BITS-1:0]  bias_q;
  logic signed [DATA_BITS-1:0]  psum_q;
  logic signed [DATA_BITS-1:0]  bias_ext;
  logic signed [DATA_BITS-1:0]  biased;
  logic        [DATA_BITS-1:0]  relu_word;

  assign bias_ext  = {{(DATA_BITS - BIAS_BITS){bias_q[BIAS_BITS-1]}}, bias_q};
  assign biased    = psum_i + bias_ext;
  assign relu_word = biased[DATA_BITS-1] ? '0 : biased; // negative results clamp to zero.

  assign busy_o = (state_q != EX_IDLE);
  assign addr_o = addr_q;

  always_comb begin
    cs_o    = 1'b0;
    oe_o    = 1'b0;
    we_o    = 1'b0;
    wdata_o = '0;
    case (state_q)
      EX_RUN: begin
        if (psum_valid_i) begin
          cs_o = 1'b1;
          if (op_q == OP_ACC) begin
            oe_o = 1'b1; // fetch the stored word first.
          end else begin
            we_o    = 1'b1;
            wdata_o = (op_q == OP_BIAS_RELU) ? relu_word : psum_i;
          end
        end
      end
      EX_ACC_WR: begin
        cs_o    = 1'b1;
        we_o    = 1'b1;
        wdata_o = rdata_i + psum_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q  <= EX_IDLE;
      addr_q   <= '0;
      remain_q <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        EX_IDLE: begin
          if (start_i) begin
            addr_q   <= base_i;
            remain_q <= count_i;
            if (op_i == OP_NOP || count_i == '0) done_o <= 1'b1;
            else state_q <= EX_RUN;
          end
        end
        EX_RUN: begin
          if (psum_valid_i) begin
            if (op_q == OP_ACC) begin
              state_q <= EX_ACC_WR;
            end else begin
              addr_q   <= addr_q + 1'b1;
              remain_q <= remain_q - 1'b1;
              if (remain_q == 1) begin
                state_q <= EX_IDLE;
                done_o  <= 1'b1;
              end
            end
          end
        end
        EX_ACC_WR: begin
          addr_q   <= addr_q + 1'b1;
          remain_q <= remain_q - 1'b1;
          done_o   <= (remain_q == 1);
          state_q  <= (remain_q == 1) ? EX_IDLE : EX_RUN;
        end
        default: state_q <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == EX_IDLE && start_i) begin
      op_q   <= op_i;
      bias_q <= bias_i;
    end
    if (state_q == EX_RUN && psum_valid_i) psum_q <= psum_i; // held for the write-back.
  end

endmodule

// ==== conv_out_top.sv ====
`timescale 1ns/1ps

module conv_out_top
  import acc_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        enb_i,
  input  logic                        cmd_valid_i,
  input  logic        [DATA_BITS-1:0] cmd_i,
  output logic                        cmd_err_o,
  output logic                        busy_o,
  output logic                        done_o,
  input  logic                        psum_valid_i,
  input  logic signed [DATA_BITS-1:0] psum_i,
  input  logic                        host_ar_hs_i,
  input  logic                        host_aw_hs_i,
  input  logic                        host_rd_fin_i,
  input  logic                        host_cs_i,
  input  logic                        host_oe_i,
  input  logic        [ADDR_BITS-1:0] host_addr_i,
  input  logic        [DATA_BITS-1:0] host_wdata_i,
  output logic                        host_rvalid_o,
  output logic        [DATA_BITS-1:0] host_rdata_o
);

  logic                  start;
  epu_op_t               op;
  logic [ADDR_BITS-1:0]  base;
  logic [COUNT_BITS-1:0] count;
  logic [BIAS_BITS-1:0]  bias;

  logic                 epu_cs;
  logic                 epu_oe;
  logic                 epu_we;
  logic [ADDR_BITS-1:0] epu_addr;
  logic [DATA_BITS-1:0] epu_wdata;
  logic [DATA_BITS-1:0] epu_rdata;

  epu_cmd_decode i_decode (
    .clk         (clk),
    .rst         (rst),
    .enb_i       (enb_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .busy_i      (busy_o),
    .start_o     (start),
    .op_o        (op),
    .base_o      (base),
    .count_o     (count),
    .bias_o      (bias),
    .cmd_err_o   (cmd_err_o)
  );

  epu_post_exec i_exec (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .op_i         (op),
    .base_i       (base),
    .count_i      (count),
    .bias_i       (bias),
    .psum_valid_i (psum_valid_i),
    .psum_i       (psum_i),
    .rdata_i      (epu_rdata),
    .cs_o         (epu_cs),
    .oe_o         (epu_oe),
    .we_o         (epu_we),
    .addr_o       (epu_addr),
    .wdata_o      (epu_wdata),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  out_buf_wrapper i_wrapper (
    .clk           (clk),
    .rst           (rst),
    .enb_i         (enb_i),
    .host_ar_hs_i  (host_ar_hs_i),
    .host_aw_hs_i  (host_aw_hs_i),
    .host_rd_fin_i (host_rd_fin_i),
    .host_cs_i     (host_cs_i),
    .host_oe_i     (host_oe_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .epu_cs_i      (epu_cs),
    .epu_oe_i      (epu_oe),
    .epu_we_i      (epu_we),
    .epu_addr_i    (epu_addr),
    .epu_wdata_i   (epu_wdata),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .epu_rdata_o   (epu_rdata)
  );

endmodule

// ==== tb_conv_out.sv ====
`timescale 1ns/1ps

module tb_conv_out
  import acc_pkg::*;
();

  localparam int N_TESTS    = 4;
  localparam int WAIT_LIMIT = 40;

  logic                        clk;
  logic                        rst;
  logic                        enb_i;
  logic                        cmd_valid_i;
  logic        [DATA_BITS-1:0] cmd_i;
  logic                        cmd_err_o;
  logic                        busy_o;
  logic                        done_o;
  logic                        psum_valid_i;
  logic signed [DATA_BITS-1:0] psum_i;
  logic                        host_ar_hs_i;
  logic                        host_aw_hs_i;
  logic                        host_rd_fin_i;
  logic                        host_cs_i;
  logic                        host_oe_i;
  logic        [ADDR_BITS-1:0] host_addr_i;
  logic        [DATA_BITS-1:0] host_wdata_i;
  logic                        host_rvalid_o;
  logic        [DATA_BITS-1:0] host_rdata_o;

  // one row per job; expected buffer words come from the reference model below.
  string                 tbl_name    [N_TESTS] = '{"pass_run", "bias_relu", "acc_preload",
                                                   "nop_cmd"};
  epu_op_t               tbl_op      [N_TESTS] = '{OP_PASS, OP_BIAS_RELU, OP_ACC, OP_NOP};
  logic [ADDR_BITS-1:0]  tbl_base    [N_TESTS] = '{8'h10, 8'h30, 8'h50, 8'h70};
  logic [COUNT_BITS-1:0] tbl_count   [N_TESTS] = '{8'd6, 8'd8, 8'd5, 8'd4};
  logic [BIAS_BITS-1:0]  tbl_bias    [N_TESTS] = '{8'h00, 8'hec, 8'h00, 8'h00};
  int                    tbl_bits    [N_TESTS] = '{32, 8, 16, 0}; // random bits per sum.
  int                    tbl_gap     [N_TESTS] = '{1, 1, 2, 1};
  bit                    tbl_preload [N_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b1};
  bit                    tbl_collide [N_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b0};

  logic [DATA_BITS-1:0] ref_mem [BUF_WORDS];
  logic [31:0]          lfsr_q;

  conv_out_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .enb_i         (enb_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .cmd_err_o     (cmd_err_o),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .psum_valid_i  (psum_valid_i),
    .psum_i        (psum_i),
    .host_ar_hs_i  (host_ar_hs_i),
    .host_aw_hs_i  (host_aw_hs_i),
    .host_rd_fin_i (host_rd_fin_i),
    .host_cs_i     (host_cs_i),
    .host_oe_i     (host_oe_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic tick();
    @(posedge clk);
    #2; // inputs change a little after the edge.
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_BITS-1:0] exp,
                            input logic [DATA_BITS-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_op_word(input string name, input epu_op_t exp, input epu_op_t act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED %s expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_sum(input int bits, output logic [DATA_BITS-1:0] sum);
    sum = '0;
    for (int b = 0; b < bits; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      sum = {sum[DATA_BITS-2:0], lfsr_q[0]};
    end
    if (bits > 0 && bits < DATA_BITS && sum[bits-1]) begin
      sum = sum | ~((32'd1 << bits) - 32'd1); // sign extend the short draw.
    end
  endtask

  function automatic logic [DATA_BITS-1:0] fill_word(input logic [ADDR_BITS-1:0] addr);
    return {8'hc0, addr, ~addr, addr ^ 8'h3c};
  endfunction

  task automatic open_access(input bit is_read);
    host_ar_hs_i = is_read;
    host_aw_hs_i = !is_read;
    tick();
    host_ar_hs_i = 1'b0;
    host_aw_hs_i = 1'b0;
  endtask

  task automatic end_access();
    host_rd_fin_i = 1'b1;
    tick();
    host_rd_fin_i = 1'b0;
  endtask

  task automatic preload_block(input logic [ADDR_BITS-1:0] base,
                               input logic [COUNT_BITS-1:0] count);
    logic [ADDR_BITS-1:0] addr;
    open_access(1'b0);
    for (int k = 0; k < int'(count); k++) begin
      addr          = base + ADDR_BITS'(k);
      host_cs_i     = 1'b1;
      host_addr_i   = addr;
      host_wdata_i  = fill_word(addr);
      ref_mem[addr] = fill_word(addr);
      tick();
    end
    host_cs_i = 1'b0;
    end_access();
  endtask

  task automatic host_read_word(input logic [ADDR_BITS-1:0] addr,
                                output logic [DATA_BITS-1:0] data);
    int n;
    n           = 0;
    host_cs_i   = 1'b1;
    host_oe_i   = 1'b1;
    host_addr_i = addr;
    @(posedge clk);
    #1;
    while (!host_rvalid_o && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    data = host_rdata_o;
    #1;
    host_cs_i = 1'b0;
    host_oe_i = 1'b0;
    if (!host_rvalid_o) stop_run($sformatf("no read data came back for address %h", addr));
  endtask

  task automatic verify_block(input string name, input logic [ADDR_BITS-1:0] base,
                              input logic [COUNT_BITS-1:0] count);
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
    open_access(1'b1);
    for (int k = 0; k < int'(count); k++) begin
      addr = base + ADDR_BITS'(k);
      host_read_word(addr, data);
      check_word($sformatf("%s[%h]", name, addr), ref_mem[addr], data);
    end
    end_access(); // the buffer goes back to the engine.
  endtask

  task automatic wait_done(input string name);
    int n;
    n = 0;
    while (!done_o && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!done_o) stop_run($sformatf("job %s never signalled done", name));
    check_flag({name, "_busy_low"}, 1'b0, busy_o);
    tick();
    check_flag({name, "_done_single"}, 1'b0, done_o);
  endtask

  task automatic run_job(input int t);
    logic        [DATA_BITS-1:0] sum;
    logic signed [DATA_BITS-1:0] biased;
    logic        [ADDR_BITS-1:0] addr;
    int n;
    cmd_valid_i = 1'b1;
    cmd_i       = {tbl_op[t], 6'd0, tbl_count[t], tbl_base[t], tbl_bias[t]};
    tick();
    cmd_valid_i = 1'b0;
    if (tbl_op[t] != OP_NOP) begin
      n = 0;
      while (!busy_o && n < WAIT_LIMIT) begin
        tick();
        n++;
      end
      if (!busy_o) stop_run($sformatf("job %s never became busy", tbl_name[t]));
      for (int i = 0; i < int'(tbl_count[t]); i++) begin
        draw_sum(tbl_bits[t], sum);
        addr = tbl_base[t] + ADDR_BITS'(i);
        case (tbl_op[t])
          OP_PASS: ref_mem[addr] = sum;
          OP_BIAS_RELU: begin
            biased = sum + {{(DATA_BITS-BIAS_BITS){tbl_bias[t][BIAS_BITS-1]}}, tbl_bias[t]};
            ref_mem[addr] = (biased < 0) ? '0 : biased;
          end
          default: ref_mem[addr] = ref_mem[addr] + sum;
        endcase
        psum_valid_i = 1'b1;
        psum_i       = sum;
        if (tbl_collide[t] && i == 1) begin
          cmd_valid_i = 1'b1; // must be refused while the job runs.
          cmd_i       = {OP_PASS, 6'd0, 8'd1, 8'h00, 8'h00};
        end
        tick();
        psum_valid_i = 1'b0;
        cmd_valid_i  = 1'b0;
        if (tbl_collide[t] && i == 1) check_flag({tbl_name[t], "_cmd_err"}, 1'b1, cmd_err_o);
        if (i < int'(tbl_count[t]) - 1) repeat (tbl_gap[t] - 1) tick();
      end
    end
    wait_done(tbl_name[t]);
    check_op_word({tbl_name[t], "_op"}, tbl_op[t], i_dut.op);
  endtask

  initial begin
    lfsr_q        = 32'hccf7_6e06;
    rst           = 1'b1;
    enb_i         = 1'b1;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    psum_valid_i  = 1'b0;
    psum_i        = '0;
    host_ar_hs_i  = 1'b0;
    host_aw_hs_i  = 1'b0;
    host_rd_fin_i = 1'b0;
    host_cs_i     = 1'b0;
    host_oe_i     = 1'b0;
    host_addr_i   = '0;
    host_wdata_i  = '0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    check_flag("reset_cmd_err", 1'b0, cmd_err_o);
    check_flag("reset_busy", 1'b0, busy_o);
    check_flag("reset_done", 1'b0, done_o);
    check_flag("reset_rvalid", 1'b0, host_rvalid_o);

    // the first host access also hands the buffer to the engine.
    preload_block(8'hf0, 8'd4);
    verify_block("host_rw", 8'hf0, 8'd4);

    for (int t = 0; t < N_TESTS; t++) begin
      if (tbl_preload[t]) begin
        preload_block(tbl_base[t], tbl_count[t]);
        verify_block({tbl_name[t], "_preload"}, tbl_base[t], tbl_count[t]);
      end
      run_job(t);
      verify_block(tbl_name[t], tbl_base[t], tbl_count[t]);
    end

    // with the enable low a read handshake opens nothing.
    enb_i = 1'b0;
    open_access(1'b1);
    host_cs_i   = 1'b1;
    host_oe_i   = 1'b1;
    host_addr_i = tbl_base[0];
    for (int n = 0; n < 8; n++) begin
      tick();
      check_flag("enb_low_rvalid", 1'b0, host_rvalid_o);
    end
    host_cs_i = 1'b0;
    host_oe_i = 1'b0;
    enb_i     = 1'b1;
    verify_block("after_enb_low", tbl_base[0], tbl_count[0]);

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== list.f ====
acc_pkg.sv
out_buf_sram.sv
out_buf_wrapper.sv
epu_cmd_decode.sv
epu_post_exec.sv
conv_out_top.sv
tb_conv_out.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_conv_out
RTL_TOP   := conv_out_top
FILELIST  := list.f
VFLAGS    := --binary --timing -j 0 -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
